// ==== hw/id_pkg.sv ====
package id_pkg;

  localparam int DATA_W     = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [DATA_W-1:0]     word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  localparam reg_addr_t LINK_REG = 5'd31;  // ra

  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02, OP_JAL   = 6'h03,
    OP_BEQ     = 6'h04, OP_BNE    = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ  = 6'h07,
    OP_ADDI    = 6'h08, OP_ADDIU  = 6'h09, OP_SLTI  = 6'h0a, OP_SLTIU = 6'h0b,
    OP_ANDI    = 6'h0c, OP_ORI    = 6'h0d, OP_XORI  = 6'h0e, OP_LUI   = 6'h0f
  } opcode_e;

  typedef enum logic [5:0] {
    FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_SRA  = 6'h03, FN_SLLV = 6'h04,
    FN_SRLV = 6'h06, FN_SRAV = 6'h07, FN_JR   = 6'h08, FN_JALR = 6'h09,
    FN_ADD  = 6'h20, FN_ADDU = 6'h21, FN_SUB  = 6'h22, FN_SUBU = 6'h23,
    FN_AND  = 6'h24, FN_OR   = 6'h25, FN_XOR  = 6'h26, FN_NOR  = 6'h27,
    FN_SLT  = 6'h2a, FN_SLTU = 6'h2b
  } funct_e;

  // rt field codes under REGIMM
  typedef enum logic [4:0] {
    RI_BLTZ = 5'h00, RI_BGEZ = 5'h01, RI_BLTZAL = 5'h10, RI_BGEZAL = 5'h11
  } regimm_e;

  typedef enum logic [7:0] {
    ALU_NOP    = 8'h00, ALU_OR     = 8'h25, ALU_AND    = 8'h24, ALU_XOR   = 8'h26,
    ALU_NOR    = 8'h27, ALU_SLL    = 8'h7c, ALU_SRL    = 8'h02, ALU_SRA   = 8'h03,
    ALU_SLT    = 8'h2a, ALU_SLTU   = 8'h2b, ALU_ADD    = 8'h20, ALU_ADDU  = 8'h21,
    ALU_SUB    = 8'h22, ALU_SUBU   = 8'h23, ALU_ADDI   = 8'h55, ALU_ADDIU = 8'h56,
    ALU_J      = 8'h4f, ALU_JAL    = 8'h50, ALU_JR     = 8'h08, ALU_JALR  = 8'h09,
    ALU_BEQ    = 8'h51, ALU_BNE    = 8'h52, ALU_BGTZ   = 8'h54, ALU_BLEZ  = 8'h53,
    ALU_BGEZ   = 8'h41, ALU_BLTZ   = 8'h40, ALU_BGEZAL = 8'h4b, ALU_BLTZAL = 8'h4a
  } aluop_e;

  typedef enum logic [2:0] {
    SEL_NOP         = 3'b000,
    SEL_LOGIC       = 3'b001,
    SEL_SHIFT       = 3'b010,
    SEL_ARITH       = 3'b100,
    SEL_JUMP_BRANCH = 3'b110
  } alusel_e;

  typedef enum logic [3:0] {
    BR_NONE, BR_J, BR_JR, BR_EQ, BR_NE, BR_GTZ, BR_LEZ, BR_GEZ, BR_LTZ
  } br_kind_e;

  typedef struct packed {
    logic      we;
    reg_addr_t dest;
    word_t     data;
  } fwd_t;

endpackage

// ==== hw/decode_if.sv ====
`timescale 1ns/100ps

interface decode_if import id_pkg::*; ();

  logic      rs_read;
  logic      rt_read;
  reg_addr_t rs_addr;
  reg_addr_t rt_addr;
  word_t     imm;
  aluop_e    aluop;
  alusel_e   alusel;
  reg_addr_t wd;
  logic      wreg;
  br_kind_e  br_kind;
  logic      link;  // writes pc+8

  modport dec (output rs_read, rt_read, rs_addr, rt_addr, imm, aluop, alusel,
               output wd, wreg, br_kind, link);
  modport opnd (input rs_read, rt_read, rs_addr, rt_addr, imm);
  modport br (input br_kind, link);
  modport pipe (input aluop, alusel, wd, wreg);

endinterface

// ==== hw/inst_decoder.sv ====
`timescale 1ns/100ps

module inst_decoder import id_pkg::*; (
  input word_t  inst_i,
  decode_if.dec dec
);

  logic [5:0] op;
  logic [5:0] funct;
  logic [4:0] rs;
  logic [4:0] rt;
  logic [4:0] rd;
  logic [4:0] shamt;
  word_t      imm_sext;
  word_t      imm_zext;

  assign op       = inst_i[31:26];
  assign rs       = inst_i[25:21];
  assign rt       = inst_i[20:16];
  assign rd       = inst_i[15:11];
  assign shamt    = inst_i[10:6];
  assign funct    = inst_i[5:0];
  assign imm_sext = {{16{inst_i[15]}}, inst_i[15:0]};
  assign imm_zext = {16'h0, inst_i[15:0]};

  assign dec.rs_addr = rs;
  assign dec.rt_addr = rt;

  function automatic aluop_e funct_aluop(input logic [5:0] f);
    case (f)
      FN_SLL, FN_SLLV: return ALU_SLL;
      FN_SRL, FN_SRLV: return ALU_SRL;
      FN_SRA, FN_SRAV: return ALU_SRA;
      FN_AND:          return ALU_AND;
      FN_OR:           return ALU_OR;
      FN_XOR:          return ALU_XOR;
      FN_NOR:          return ALU_NOR;
      FN_ADD:          return ALU_ADD;
      FN_ADDU:         return ALU_ADDU;
      FN_SUB:          return ALU_SUB;
      FN_SUBU:         return ALU_SUBU;
      FN_SLT:          return ALU_SLT;
      FN_SLTU:         return ALU_SLTU;
      FN_JR:           return ALU_JR;
      FN_JALR:         return ALU_JALR;
      default:         return ALU_NOP;
    endcase
  endfunction

  // primary opcodes only, SPECIAL and REGIMM fall to nop here
  function automatic aluop_e op_aluop(input logic [5:0] o);
    case (o)
      OP_ORI, OP_LUI: return ALU_OR;
      OP_ANDI:        return ALU_AND;
      OP_XORI:        return ALU_XOR;
      OP_ADDI:        return ALU_ADDI;
      OP_ADDIU:       return ALU_ADDIU;
      OP_SLTI:        return ALU_SLT;
      OP_SLTIU:       return ALU_SLTU;
      OP_J:           return ALU_J;
      OP_JAL:         return ALU_JAL;
      OP_BEQ:         return ALU_BEQ;
      OP_BNE:         return ALU_BNE;
      OP_BLEZ:        return ALU_BLEZ;
      OP_BGTZ:        return ALU_BGTZ;
      default:        return ALU_NOP;
    endcase
  endfunction

  always_comb begin
    dec.rs_read = 1'b0;
    dec.rt_read = 1'b0;
    dec.imm     = '0;
    dec.aluop   = op_aluop(op);
    dec.alusel  = SEL_NOP;
    dec.wd      = '0;
    dec.wreg    = 1'b0;
    dec.br_kind = BR_NONE;
    dec.link    = 1'b0;
    case (op)
      OP_SPECIAL: begin
        case (funct)
          FN_SLL, FN_SRL, FN_SRA: begin
            if (rs == 5'd0) begin
              dec.rt_read = 1'b1;
              dec.imm     = {27'h0, shamt};  // shift amount as operand 1
              dec.aluop   = funct_aluop(funct);
              dec.alusel  = SEL_SHIFT;
              dec.wd      = rd;
              dec.wreg    = 1'b1;
            end
          end
          FN_SLLV, FN_SRLV, FN_SRAV, FN_AND, FN_OR, FN_XOR, FN_NOR,
          FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU: begin
            if (shamt == 5'd0) begin
              dec.rs_read = 1'b1;
              dec.rt_read = 1'b1;
              dec.aluop   = funct_aluop(funct);
              // 0001xx shifts, 1001xx logic, rest arith
              dec.alusel  = !funct[5] ? SEL_SHIFT :
                            (funct[5:2] == 4'b1001) ? SEL_LOGIC : SEL_ARITH;
              dec.wd      = rd;
              dec.wreg    = 1'b1;
            end
          end
          FN_JR, FN_JALR: begin
            if (shamt == 5'd0) begin
              dec.rs_read = 1'b1;
              dec.aluop   = funct_aluop(funct);
              dec.alusel  = SEL_JUMP_BRANCH;
              dec.br_kind = BR_JR;
              if (funct == FN_JALR) begin
                dec.wd   = rd;
                dec.wreg = 1'b1;
                dec.link = 1'b1;
              end
            end
          end
          default: ;
        endcase
      end
      OP_REGIMM: begin
        if (rt inside {RI_BLTZ, RI_BGEZ, RI_BLTZAL, RI_BGEZAL}) begin
          dec.rs_read = 1'b1;
          dec.alusel  = SEL_JUMP_BRANCH;
          dec.br_kind = rt[0] ? BR_GEZ : BR_LTZ;
          dec.link    = rt[4];  // al forms
          dec.wreg    = rt[4];
          dec.wd      = rt[4] ? LINK_REG : '0;
          case (rt)
            RI_BLTZ:   dec.aluop = ALU_BLTZ;
            RI_BGEZ:   dec.aluop = ALU_BGEZ;
            RI_BLTZAL: dec.aluop = ALU_BLTZAL;
            default:   dec.aluop = ALU_BGEZAL;
          endcase
        end
      end
      OP_ORI, OP_ANDI, OP_XORI, OP_LUI: begin
        dec.rs_read = 1'b1;
        dec.imm     = (op == OP_LUI) ? {inst_i[15:0], 16'h0} : imm_zext;
        dec.alusel  = SEL_LOGIC;
        dec.wd      = rt;
        dec.wreg    = 1'b1;
      end
      OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
        dec.rs_read = 1'b1;
        dec.imm     = imm_sext;
        dec.alusel  = SEL_ARITH;
        dec.wd      = rt;
        dec.wreg    = 1'b1;
      end
      OP_J, OP_JAL: begin
        dec.alusel  = SEL_JUMP_BRANCH;
        dec.br_kind = BR_J;
        if (op == OP_JAL) begin
          dec.wd   = LINK_REG;
          dec.wreg = 1'b1;
          dec.link = 1'b1;
        end
      end
      OP_BEQ, OP_BNE: begin
        dec.rs_read = 1'b1;
        dec.rt_read = 1'b1;
        dec.alusel  = SEL_JUMP_BRANCH;
        dec.br_kind = (op == OP_BEQ) ? BR_EQ : BR_NE;
      end
      OP_BLEZ, OP_BGTZ: begin
        dec.rs_read = 1'b1;
        dec.alusel  = SEL_JUMP_BRANCH;
        dec.br_kind = (op == OP_BLEZ) ? BR_LEZ : BR_GTZ;
      end
      default: ;  // invalid, stays nop
    endcase
  end

endmodule

// ==== hw/operand_mux.sv ====
`timescale 1ns/100ps

module operand_mux import id_pkg::*; #(
  parameter int SEL_RT = 0
) (
  decode_if.opnd dec,
  input  fwd_t   ex_fwd_i,
  input  fwd_t   mem_fwd_i,
  input  word_t  rf_data_i,
  output word_t  operand_o
);

  logic      rd_en;
  reg_addr_t addr;

  assign rd_en = (SEL_RT != 0) ? dec.rt_read : dec.rs_read;
  assign addr  = (SEL_RT != 0) ? dec.rt_addr : dec.rs_addr;

  // youngest result wins, r0 not excluded
  always_comb begin
    if (!rd_en) begin
      operand_o = dec.imm;
    end else if (ex_fwd_i.we && (ex_fwd_i.dest == addr)) begin
      operand_o = ex_fwd_i.data;
    end else if (mem_fwd_i.we && (mem_fwd_i.dest == addr)) begin
      operand_o = mem_fwd_i.data;
    end else begin
      operand_o = rf_data_i;
    end
  end

endmodule

// ==== hw/branch_unit.sv ====
`timescale 1ns/100ps

module branch_unit import id_pkg::*; (
  decode_if.br  dec,
  input  word_t pc_i,
  input  word_t inst_i,
  input  word_t reg1_i,
  input  word_t reg2_i,
  output logic  branch_flag_o,
  output word_t branch_target_o,
  output word_t link_addr_o
);

  word_t pc_plus_4;
  word_t pc_plus_8;
  word_t br_offset;
  word_t target;
  logic  taken;

  assign pc_plus_4 = pc_i + 32'd4;
  assign pc_plus_8 = pc_i + 32'd8;
  assign br_offset = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};

  always_comb begin
    taken  = 1'b0;
    target = pc_plus_4 + br_offset;  // conditional kinds
    case (dec.br_kind)
      BR_J: begin
        taken  = 1'b1;
        target = {pc_plus_4[31:28], inst_i[25:0], 2'b00};
      end
      BR_JR: begin
        taken  = 1'b1;
        target = reg1_i;
      end
      BR_EQ:  taken = (reg1_i == reg2_i);
      BR_NE:  taken = (reg1_i != reg2_i);
      BR_GTZ: taken = !reg1_i[31] && (reg1_i != '0);
      BR_LEZ: taken = reg1_i[31] || (reg1_i == '0);
      BR_GEZ: taken = !reg1_i[31];
      BR_LTZ: taken = reg1_i[31];
      default: taken = 1'b0;
    endcase
  end

  assign branch_flag_o   = taken;
  assign branch_target_o = taken ? target : '0;
  assign link_addr_o     = dec.link ? pc_plus_8 : '0;  // return past delay slot

endmodule

// ==== hw/id_ex_reg.sv ====
`timescale 1ns/100ps

module id_ex_reg import id_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  decode_if.pipe    dec,
  input  word_t     reg1_i,
  input  word_t     reg2_i,
  input  word_t     link_addr_i,
  input  logic      branch_flag_i,
  output aluop_e    ex_aluop_o,
  output alusel_e   ex_alusel_o,
  output word_t     ex_reg1_o,
  output word_t     ex_reg2_o,
  output reg_addr_t ex_wd_o,
  output logic      ex_wreg_o,
  output word_t     ex_link_addr_o,
  output logic      ex_in_delayslot_o
);

  logic delayslot_q;  // instruction now in decode follows a taken branch

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      delayslot_q       <= 1'b0;
      ex_aluop_o        <= ALU_NOP;
      ex_alusel_o       <= SEL_NOP;
      ex_reg1_o         <= '0;
      ex_reg2_o         <= '0;
      ex_wd_o           <= '0;
      ex_wreg_o         <= 1'b0;
      ex_link_addr_o    <= '0;
      ex_in_delayslot_o <= 1'b0;
    end else begin
      delayslot_q       <= branch_flag_i;
      ex_aluop_o        <= dec.aluop;
      ex_alusel_o       <= dec.alusel;
      ex_reg1_o         <= reg1_i;
      ex_reg2_o         <= reg2_i;
      ex_wd_o           <= dec.wd;
      ex_wreg_o         <= dec.wreg;
      ex_link_addr_o    <= link_addr_i;
      ex_in_delayslot_o <= delayslot_q;
    end
  end

endmodule

// ==== hw/id_stage.sv ====
`timescale 1ns/100ps

module id_stage import id_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  word_t     pc_i,
  input  word_t     inst_i,
  output logic      reg1_read_o,
  output reg_addr_t reg1_addr_o,
  input  word_t     reg1_data_i,
  output logic      reg2_read_o,
  output reg_addr_t reg2_addr_o,
  input  word_t     reg2_data_i,
  input  logic      ex_wreg_i,
  input  reg_addr_t ex_wd_i,
  input  word_t     ex_wdata_i,
  input  logic      mem_wreg_i,
  input  reg_addr_t mem_wd_i,
  input  word_t     mem_wdata_i,
  output logic      branch_flag_o,
  output word_t     branch_target_o,
  output aluop_e    ex_aluop_o,
  output alusel_e   ex_alusel_o,
  output word_t     ex_reg1_o,
  output word_t     ex_reg2_o,
  output reg_addr_t ex_wd_o,
  output logic      ex_wreg_o,
  output word_t     ex_link_addr_o,
  output logic      ex_in_delayslot_o
);

  decode_if dec_if ();

  fwd_t  ex_fwd;
  fwd_t  mem_fwd;
  word_t reg1;
  word_t reg2;
  word_t link_addr;

  assign ex_fwd  = '{we: ex_wreg_i, dest: ex_wd_i, data: ex_wdata_i};
  assign mem_fwd = '{we: mem_wreg_i, dest: mem_wd_i, data: mem_wdata_i};

  // regfile read ports, same cycle
  assign reg1_read_o = dec_if.rs_read;
  assign reg1_addr_o = dec_if.rs_addr;
  assign reg2_read_o = dec_if.rt_read;
  assign reg2_addr_o = dec_if.rt_addr;

  inst_decoder u_inst_decoder (
    .inst_i (inst_i),
    .dec    (dec_if)
  );

  operand_mux #(.SEL_RT(0)) u_opnd_rs (
    .dec       (dec_if),
    .ex_fwd_i  (ex_fwd),
    .mem_fwd_i (mem_fwd),
    .rf_data_i (reg1_data_i),
    .operand_o (reg1)
  );

  operand_mux #(.SEL_RT(1)) u_opnd_rt (
    .dec       (dec_if),
    .ex_fwd_i  (ex_fwd),
    .mem_fwd_i (mem_fwd),
    .rf_data_i (reg2_data_i),
    .operand_o (reg2)
  );

  branch_unit u_branch_unit (
    .dec             (dec_if),
    .pc_i            (pc_i),
    .inst_i          (inst_i),
    .reg1_i          (reg1),
    .reg2_i          (reg2),
    .branch_flag_o   (branch_flag_o),
    .branch_target_o (branch_target_o),
    .link_addr_o     (link_addr)
  );

  id_ex_reg u_id_ex_reg (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .dec               (dec_if),
    .reg1_i            (reg1),
    .reg2_i            (reg2),
    .link_addr_i       (link_addr),
    .branch_flag_i     (branch_flag_o),
    .ex_aluop_o        (ex_aluop_o),
    .ex_alusel_o       (ex_alusel_o),
    .ex_reg1_o         (ex_reg1_o),
    .ex_reg2_o         (ex_reg2_o),
    .ex_wd_o           (ex_wd_o),
    .ex_wreg_o         (ex_wreg_o),
    .ex_link_addr_o    (ex_link_addr_o),
    .ex_in_delayslot_o (ex_in_delayslot_o)
  );

endmodule

// ==== verif/id_stage_checker.sv ====
`timescale 1ns/100ps

module id_stage_checker (
  input logic clk_i,
  input logic rst_n_i,
  input logic branch_flag_i,
  input logic delayslot_i,
  input logic wreg_i
);

  // no write leaves the stage while in reset
  assert property (@(posedge clk_i) !rst_n_i |-> !wreg_i)
    else $error("ex_wreg_o set during reset");

  // flag seen at edge N, decode slot N+1, registered at N+2
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   $rose(delayslot_i) |-> $past(branch_flag_i, 2))
    else $error("delay slot flag without a preceding taken branch");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   $past(branch_flag_i, 2) && $past(rst_n_i, 2) |-> delayslot_i)
    else $error("taken branch not followed by a delay slot mark");

endmodule

bind id_stage id_stage_checker u_id_stage_checker (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .branch_flag_i (branch_flag_o),
  .delayslot_i   (ex_in_delayslot_o),
  .wreg_i        (ex_wreg_o)
);

// ==== verif/id_ref_model.svh ====
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

// branch kinds as seen by the model
localparam logic [3:0] K_NONE = 4'd0;
localparam logic [3:0] K_J    = 4'd1;
localparam logic [3:0] K_JR   = 4'd2;
localparam logic [3:0] K_EQ   = 4'd3;
localparam logic [3:0] K_NE   = 4'd4;
localparam logic [3:0] K_GTZ  = 4'd5;
localparam logic [3:0] K_LEZ  = 4'd6;
localparam logic [3:0] K_GEZ  = 4'd7;
localparam logic [3:0] K_LTZ  = 4'd8;

typedef struct packed {
  logic       rs_rd;
  logic       rt_rd;
  word_t      imm;
  logic [7:0] aluop;
  logic [2:0] alusel;
  logic [4:0] wd;
  logic       wreg;
  logic [3:0] kind;
  logic       link;
} dec_exp_t;

function automatic dec_exp_t decode_ref(input word_t inst);
  dec_exp_t   d;
  logic [5:0] op;
  logic [5:0] fn;
  logic [4:0] rs;
  logic [4:0] rt;
  logic [4:0] rd;
  logic [4:0] sa;
  d  = '0;  // all-zero is the nop
  op = inst[31:26];
  rs = inst[25:21];
  rt = inst[20:16];
  rd = inst[15:11];
  sa = inst[10:6];
  fn = inst[5:0];
  case (op)
    6'h00: begin
      if ((fn == 6'h00 || fn == 6'h02 || fn == 6'h03) && rs == 5'd0) begin
        d.rt_rd  = 1'b1;
        d.imm    = {27'h0, sa};
        d.alusel = SEL_SHIFT;
        d.aluop  = (fn == 6'h00) ? ALU_SLL : (fn == 6'h02) ? ALU_SRL : ALU_SRA;
        d.wd     = rd;
        d.wreg   = 1'b1;
      end else if ((fn == 6'h08 || fn == 6'h09) && sa == 5'd0) begin
        d.rs_rd  = 1'b1;
        d.alusel = SEL_JUMP_BRANCH;
        d.kind   = K_JR;
        d.aluop  = (fn == 6'h08) ? ALU_JR : ALU_JALR;
        if (fn == 6'h09) begin
          d.link = 1'b1;
          d.wd   = rd;
          d.wreg = 1'b1;
        end
      end else if (sa == 5'd0) begin
        case (fn)
          6'h04: begin d.aluop = ALU_SLL;  d.alusel = SEL_SHIFT; end
          6'h06: begin d.aluop = ALU_SRL;  d.alusel = SEL_SHIFT; end
          6'h07: begin d.aluop = ALU_SRA;  d.alusel = SEL_SHIFT; end
          6'h24: begin d.aluop = ALU_AND;  d.alusel = SEL_LOGIC; end
          6'h25: begin d.aluop = ALU_OR;   d.alusel = SEL_LOGIC; end
          6'h26: begin d.aluop = ALU_XOR;  d.alusel = SEL_LOGIC; end
          6'h27: begin d.aluop = ALU_NOR;  d.alusel = SEL_LOGIC; end
          6'h20: begin d.aluop = ALU_ADD;  d.alusel = SEL_ARITH; end
          6'h21: begin d.aluop = ALU_ADDU; d.alusel = SEL_ARITH; end
          6'h22: begin d.aluop = ALU_SUB;  d.alusel = SEL_ARITH; end
          6'h23: begin d.aluop = ALU_SUBU; d.alusel = SEL_ARITH; end
          6'h2a: begin d.aluop = ALU_SLT;  d.alusel = SEL_ARITH; end
          6'h2b: begin d.aluop = ALU_SLTU; d.alusel = SEL_ARITH; end
          default: ;
        endcase
        if (d.alusel != SEL_NOP) begin
          d.rs_rd = 1'b1;
          d.rt_rd = 1'b1;
          d.wd    = rd;
          d.wreg  = 1'b1;
        end
      end
    end
    6'h01: begin
      if (rt == 5'h00 || rt == 5'h01 || rt == 5'h10 || rt == 5'h11) begin
        d.rs_rd  = 1'b1;
        d.alusel = SEL_JUMP_BRANCH;
        d.kind   = rt[0] ? K_GEZ : K_LTZ;
        d.link   = rt[4];
        d.wreg   = rt[4];
        d.wd     = rt[4] ? 5'd31 : 5'd0;
        case (rt)
          5'h00:   d.aluop = ALU_BLTZ;
          5'h01:   d.aluop = ALU_BGEZ;
          5'h10:   d.aluop = ALU_BLTZAL;
          default: d.aluop = ALU_BGEZAL;
        endcase
      end
    end
    6'h02, 6'h03: begin
      d.alusel = SEL_JUMP_BRANCH;
      d.kind   = K_J;
      d.aluop  = (op == 6'h02) ? ALU_J : ALU_JAL;
      if (op == 6'h03) begin
        d.link = 1'b1;
        d.wd   = 5'd31;
        d.wreg = 1'b1;
      end
    end
    6'h04, 6'h05, 6'h06, 6'h07: begin
      d.rs_rd  = 1'b1;
      d.rt_rd  = !op[1];  // only beq/bne compare two registers
      d.alusel = SEL_JUMP_BRANCH;
      case (op[1:0])
        2'd0:    begin d.kind = K_EQ;  d.aluop = ALU_BEQ;  end
        2'd1:    begin d.kind = K_NE;  d.aluop = ALU_BNE;  end
        2'd2:    begin d.kind = K_LEZ; d.aluop = ALU_BLEZ; end
        default: begin d.kind = K_GTZ; d.aluop = ALU_BGTZ; end
      endcase
    end
    6'h08, 6'h09, 6'h0a, 6'h0b: begin
      d.rs_rd  = 1'b1;
      d.imm    = {{16{inst[15]}}, inst[15:0]};
      d.alusel = SEL_ARITH;
      d.wd     = rt;
      d.wreg   = 1'b1;
      case (op[1:0])
        2'd0:    d.aluop = ALU_ADDI;
        2'd1:    d.aluop = ALU_ADDIU;
        2'd2:    d.aluop = ALU_SLT;
        default: d.aluop = ALU_SLTU;
      endcase
    end
    6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
      d.rs_rd  = 1'b1;
      d.imm    = (op == 6'h0f) ? {inst[15:0], 16'h0} : {16'h0, inst[15:0]};
      d.alusel = SEL_LOGIC;
      d.wd     = rt;
      d.wreg   = 1'b1;
      case (op[1:0])
        2'd0:    d.aluop = ALU_AND;
        2'd2:    d.aluop = ALU_XOR;
        default: d.aluop = ALU_OR;  // ori and lui
      endcase
    end
    default: ;
  endcase
  return d;
endfunction

function automatic word_t operand_ref(input logic rd_en, input logic [4:0] addr,
                                      input word_t imm, input logic ex_we,
                                      input logic [4:0] ex_dst, input word_t ex_dat,
                                      input logic mem_we, input logic [4:0] mem_dst,
                                      input word_t mem_dat, input word_t rf_dat);
  if (!rd_en) return imm;
  if (ex_we && ex_dst == addr) return ex_dat;
  if (mem_we && mem_dst == addr) return mem_dat;
  return rf_dat;
endfunction

function automatic logic taken_ref(input logic [3:0] kind, input word_t a, input word_t b);
  case (kind)
    K_J, K_JR: return 1'b1;
    K_EQ:      return a == b;
    K_NE:      return a != b;
    K_GTZ:     return $signed(a) > 0;
    K_LEZ:     return $signed(a) <= 0;
    K_GEZ:     return $signed(a) >= 0;
    K_LTZ:     return $signed(a) < 0;
    default:   return 1'b0;
  endcase
endfunction

function automatic word_t target_ref(input logic [3:0] kind, input word_t pc,
                                     input word_t inst, input word_t a);
  word_t seq;
  seq = pc + 32'd4;
  if (kind == K_J) return {seq[31:28], inst[25:0], 2'b00};
  if (kind == K_JR) return a;
  return seq + ({{16{inst[15]}}, inst[15:0]} << 2);
endfunction

`endif

// ==== verif/tb_id_stage.sv ====
`timescale 1ns/100ps

module tb_id_stage import id_pkg::*; ();

  localparam int NUM_CYCLES     = 2000;
  localparam int TIMEOUT_CYCLES = 5000;

  localparam logic [5:0] FUNCT_LIST [0:17] = '{
    6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09, 6'h20,
    6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b
  };

  `include "id_ref_model.svh"

  logic      clk;
  logic      rst_n;
  word_t     pc;
  word_t     inst;
  word_t     reg1_data;
  word_t     reg2_data;
  logic      ex_wreg;
  reg_addr_t ex_wd;
  word_t     ex_wdata;
  logic      mem_wreg;
  reg_addr_t mem_wd;
  word_t     mem_wdata;
  logic      reg1_read;
  reg_addr_t reg1_addr;
  logic      reg2_read;
  reg_addr_t reg2_addr;
  logic      branch_flag;
  word_t     branch_target;
  aluop_e    ex_aluop;
  alusel_e   ex_alusel;
  word_t     ex_reg1;
  word_t     ex_reg2;
  reg_addr_t ex_wd_q;
  logic      ex_wreg_q;
  word_t     ex_link_addr;
  logic      ex_in_delayslot;

  integer   seed = 32'hef9c;
  int       err_cnt;
  int       chk_cnt;
  logic     done;
  dec_exp_t d;
  word_t    op1;
  word_t    op2;
  logic     taken;
  logic     prev_taken;
  logic     have_exp;
  word_t    exp_q [0:7];  // saved registered expectation

  id_stage u_id_stage (
    .clk_i (clk), .rst_n_i (rst_n), .pc_i (pc), .inst_i (inst),
    .reg1_read_o (reg1_read), .reg1_addr_o (reg1_addr), .reg1_data_i (reg1_data),
    .reg2_read_o (reg2_read), .reg2_addr_o (reg2_addr), .reg2_data_i (reg2_data),
    .ex_wreg_i (ex_wreg), .ex_wd_i (ex_wd), .ex_wdata_i (ex_wdata),
    .mem_wreg_i (mem_wreg), .mem_wd_i (mem_wd), .mem_wdata_i (mem_wdata),
    .branch_flag_o (branch_flag), .branch_target_o (branch_target),
    .ex_aluop_o (ex_aluop), .ex_alusel_o (ex_alusel), .ex_reg1_o (ex_reg1),
    .ex_reg2_o (ex_reg2), .ex_wd_o (ex_wd_q), .ex_wreg_o (ex_wreg_q),
    .ex_link_addr_o (ex_link_addr), .ex_in_delayslot_o (ex_in_delayslot)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] rnd();
    rnd = $random(seed);
  endfunction

  // mostly kept encodings plus a few broken ones
  function automatic word_t gen_inst();
    logic [31:0] r;
    word_t       w;
    int          k;
    r = rnd();
    w = rnd();
    k = int'(r[7:0]) % 12;
    case (k)
      0, 1: begin
        w[31:26] = 6'h00;
        w[5:0]   = FUNCT_LIST[int'(r[16:12]) % 18];
        if (!(r[8] && r[9] && r[10])) begin
          if (w[5:0] <= 6'h03) w[25:21] = 5'd0;
          else w[10:6] = 5'd0;
        end
      end
      2: begin
        w[31:26] = 6'h01;
        if (r[11:8] != 4'hf) w[20:16] = {r[9], 3'b000, r[10]};
      end
      3:       w[31:26] = {5'b00001, r[9]};
      4, 5:    w[31:26] = {4'b0001, r[10:9]};
      6, 7, 8: w[31:26] = {3'b001, r[11:9]};
      9: begin
        w[31:26] = 6'h00;
        w[10:6]  = 5'd0;
        w[5:0]   = {5'b00010, r[9]};
      end
      default: ;  // fully random word
    endcase
    return w;
  endfunction

  function automatic logic [4:0] pick_addr(input logic [1:0] sel, input word_t w);
    if (sel == 2'd0) return w[25:21];
    if (sel == 2'd1) return w[20:16];
    return w[15:11] ^ w[4:0];
  endfunction

  task automatic check_val(input string what, input logic [31:0] got,
                           input logic [31:0] exp);
    chk_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("FAIL %0t ns: %s got %08h expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    r         = rnd();
    inst      = gen_inst();
    pc        = {rnd() & 32'hffff_fffc};
    reg1_data = r[1:0] == 2'd0 ? 32'h0 : rnd();
    reg2_data = r[3:2] == 2'd0 ? reg1_data : rnd();
    ex_wreg   = r[4];
    ex_wd     = pick_addr(r[6:5], inst);
    ex_wdata  = rnd();
    mem_wreg  = r[7];
    mem_wd    = pick_addr(r[9:8], inst);
    mem_wdata = r[11:10] == 2'd0 ? 32'h8000_0000 : rnd();
  endtask

  task automatic check_registered();
    check_val("ex_aluop", 32'(ex_aluop), exp_q[0]);
    check_val("ex_alusel", 32'(ex_alusel), exp_q[1]);
    check_val("ex_reg1", ex_reg1, exp_q[2]);
    check_val("ex_reg2", ex_reg2, exp_q[3]);
    check_val("ex_wd", 32'(ex_wd_q), exp_q[4]);
    check_val("ex_wreg", 32'(ex_wreg_q), exp_q[5]);
    check_val("ex_link_addr", ex_link_addr, exp_q[6]);
    check_val("ex_in_delayslot", 32'(ex_in_delayslot), exp_q[7]);
  endtask

  task automatic check_comb();
    d   = decode_ref(inst);
    op1 = operand_ref(d.rs_rd, inst[25:21], d.imm, ex_wreg, ex_wd, ex_wdata,
                      mem_wreg, mem_wd, mem_wdata, reg1_data);
    op2 = operand_ref(d.rt_rd, inst[20:16], d.imm, ex_wreg, ex_wd, ex_wdata,
                      mem_wreg, mem_wd, mem_wdata, reg2_data);
    taken = taken_ref(d.kind, op1, op2);
    check_val("reg1_read", 32'(reg1_read), 32'(d.rs_rd));
    check_val("reg1_addr", 32'(reg1_addr), 32'(inst[25:21]));
    check_val("reg2_read", 32'(reg2_read), 32'(d.rt_rd));
    check_val("reg2_addr", 32'(reg2_addr), 32'(inst[20:16]));
    check_val("branch_flag", 32'(branch_flag), 32'(taken));
    check_val("branch_target", branch_target,
              taken ? target_ref(d.kind, pc, inst, op1) : 32'h0);
  endtask

  task automatic save_expect();
    exp_q[0] = 32'(d.aluop);
    exp_q[1] = 32'(d.alusel);
    exp_q[2] = op1;
    exp_q[3] = op2;
    exp_q[4] = 32'(d.wd);
    exp_q[5] = 32'(d.wreg);
    exp_q[6] = d.link ? pc + 32'd8 : 32'h0;
    exp_q[7] = 32'(prev_taken);  // previous instruction branched
    prev_taken = taken;
    have_exp   = 1'b1;
  endtask

  initial begin
    rst_n = 1'b0;
    pc = '0;
    inst = '0;
    reg1_data = '0;
    reg2_data = '0;
    ex_wreg = 1'b0;
    ex_wd = '0;
    ex_wdata = '0;
    mem_wreg = 1'b0;
    mem_wd = '0;
    mem_wdata = '0;
    err_cnt = 0;
    chk_cnt = 0;
    done = 1'b0;
    prev_taken = 1'b0;
    have_exp = 1'b0;
    for (int i = 0; i < 8; i++) exp_q[i] = '0;
    repeat (5) @(posedge clk);
    #1;
    check_registered();  // all zero in reset
    rst_n = 1'b1;
    for (int c = 0; c < NUM_CYCLES; c++) begin
      @(posedge clk);
      #1;
      if (have_exp) check_registered();
      drive_inputs();
      #3;
      check_comb();
      save_expect();
    end
    @(posedge clk);
    #1;
    check_registered();  // last instruction leaves the register
    done = 1'b1;
    $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    for (int i = 0; i < TIMEOUT_CYCLES && !done; i++) @(posedge clk);
    if (!done) begin
      $display("timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

endmodule

// ==== tb.f ====
+incdir+verif
hw/id_pkg.sv
hw/decode_if.sv
hw/inst_decoder.sv
hw/operand_mux.sv
hw/branch_unit.sv
hw/id_ex_reg.sv
hw/id_stage.sv
verif/id_stage_checker.sv
verif/tb_id_stage.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_id_stage -o sim_tb
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "RESULT: PASS" <<< "$out"; then
  exit 0
fi
exit 1
